// ==== common/uf_pkg.sv ====
package uf_pkg;

    localparam int coord_width = 5;

    typedef logic [coord_width-1:0] coord_t;

    // k is the top field so whole-vector compares order by k, then i, then j
    typedef struct packed {
        coord_t k;
        coord_t i;
        coord_t j;
    } address_t;

    typedef enum logic [2:0] {
        stage_idle                = 3'd0,
        stage_spread_cluster      = 3'd1,
        stage_grow_boundary       = 3'd2,
        stage_sync_is_odd_cluster = 3'd3,
        stage_measurement_loading = 3'd4
    } stage_t;

    typedef logic [1:0] cost_t;   // boundary cost and grow count

    // what one neighbor link presents to the unit
    typedef struct packed {
        logic     is_fully_grown;
        logic     is_odd_cluster;
        address_t root;
    } neighbor_t;

    // published unit state
    typedef struct packed {
        address_t old_root;
        address_t updated_root;
        logic     is_error_syndrome;
        logic     is_odd_cluster;
        logic     is_touching_boundary;
        logic     is_odd_cardinality;
    } pu_status_t;

endpackage

// ==== hw/stage_tracker.sv ====
`timescale 1ns/1ps

module stage_tracker (
    input  logic           clk,
    input  logic           reset,
    input  uf_pkg::stage_t stage_in,
    output uf_pkg::stage_t stage,
    output logic           enter_grow,
    output logic           enter_sync
);
    import uf_pkg::*;

    stage_t last_stage;   // stage of the previous cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            stage      <= stage_idle;
            last_stage <= stage_idle;
        end else begin
            stage <= stage_in;
            // loading wipes the history, whatever follows is a fresh entry
            if (stage == stage_measurement_loading) begin
                last_stage <= stage_idle;
            end else begin
                last_stage <= stage;
            end
        end
    end

    // high only on the first cycle of the stage
    assign enter_grow = (stage == stage_grow_boundary)
                        && (last_stage != stage_grow_boundary);
    assign enter_sync = (stage == stage_sync_is_odd_cluster)
                        && (last_stage != stage_sync_is_odd_cluster);

endmodule

// ==== hw/root_compare_tree.sv ====
`timescale 1ns/1ps

module root_compare_tree #(
    parameter int neighbor_count = 6
) (
    input  uf_pkg::address_t       default_root,
    input  uf_pkg::address_t       roots [neighbor_count],
    input  logic [neighbor_count-1:0] valids,
    output uf_pkg::address_t       min_root
);
    import uf_pkg::*;

    localparam int tree_depth = $clog2(neighbor_count);
    localparam int leaf_count = 1 << tree_depth;      // padded to a power of two
    localparam int node_count = 2 * leaf_count - 1;

    // heap layout: node n has children 2n+1 and 2n+2, leaves at the tail
    address_t              node_root [node_count];
    logic [node_count-1:0] node_valid;

    for (genvar n = 0; n < leaf_count; n++) begin : g_leaf
        if (n < neighbor_count) begin : g_used
            assign node_root[leaf_count - 1 + n]  = roots[n];
            assign node_valid[leaf_count - 1 + n] = valids[n];
        end else begin : g_pad
            assign node_root[leaf_count - 1 + n]  = '0;
            assign node_valid[leaf_count - 1 + n] = 1'b0;   // empty leaf, never wins
        end
    end

    // pairwise minimum cells, an invalid side always loses
    for (genvar n = 0; n < leaf_count - 1; n++) begin : g_cell
        logic pick_left;

        assign pick_left = node_valid[2*n+1]
                           && (!node_valid[2*n+2]
                               || (node_root[2*n+1] <= node_root[2*n+2]));
        assign node_root[n]  = pick_left ? node_root[2*n+1] : node_root[2*n+2];
        assign node_valid[n] = node_valid[2*n+1] | node_valid[2*n+2];
    end

    // winner only counts if it beats the current root
    assign min_root = (node_valid[0] && (node_root[0] < default_root))
                      ? node_root[0] : default_root;

endmodule

// ==== hw/boundary_tracker.sv ====
`timescale 1ns/1ps

module boundary_tracker #(
    parameter int pos_j            = 0,
    parameter int pos_k            = 0,
    parameter int code_distance_z  = 12,
    parameter int boundary_cost_z  = 2,
    parameter int boundary_cost_ud = 2
) (
    input  logic           clk,
    input  logic           reset,
    input  uf_pkg::stage_t stage,
    input  logic           enter_grow,
    input  logic           is_odd_cluster,
    output logic           boundary_touch
);
    import uf_pkg::*;

    localparam int boundary_count = 2;   // 0 is Z, 1 is UD

    // Z boundary sits on both ends of the j axis, UD only at the first round
    localparam bit has_boundary_z  = (pos_j == 0) || (pos_j == code_distance_z - 1);
    localparam bit has_boundary_ud = (pos_k == 0);

    logic [boundary_count-1:0] touch;
    logic                      grow_step;

    assign grow_step = enter_grow && is_odd_cluster;   // one step per grow round

    for (genvar b = 0; b < boundary_count; b++) begin : g_boundary
        localparam bit    present = (b == 0) ? has_boundary_z : has_boundary_ud;
        localparam cost_t cost    = (b == 0) ? cost_t'(boundary_cost_z)
                                             : cost_t'(boundary_cost_ud);

        cost_t grown;   // how far this boundary edge has grown

        always_ff @(posedge clk) begin
            if (reset) begin
                grown <= '0;
            end else if (stage == stage_measurement_loading) begin
                grown <= '0;
            end else if (grow_step && present && (grown < cost)) begin
                grown <= grown + 1'b1;
            end
        end

        // edge fully grown onto the boundary
        assign touch[b] = present && (grown == cost);
    end

    assign boundary_touch = |touch;

endmodule

// ==== processing_unit/cluster_state.sv ====
`timescale 1ns/1ps

module cluster_state #(
    parameter int neighbor_count = 6,
    parameter int pos_i          = 0,
    parameter int pos_j          = 0,
    parameter int pos_k          = 0
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               init_is_error_syndrome,
    input  uf_pkg::stage_t     stage,
    input  logic               enter_sync,
    input  logic               enter_grow,
    input  uf_pkg::neighbor_t  neighbors [neighbor_count],
    input  uf_pkg::address_t   min_root,
    input  logic               boundary_touch,
    output uf_pkg::pu_status_t status,
    output logic               neighbor_increase,
    output logic               is_processing
);
    import uf_pkg::*;

    localparam address_t own_address = '{
        k: coord_t'(pos_k),
        i: coord_t'(pos_i),
        j: coord_t'(pos_j)
    };

    pu_status_t                state;
    logic [neighbor_count-1:0] neighbor_odd;
    logic                      self_odd;
    logic                      next_odd_cluster;
    logic                      spread_change;
    logic                      sync_change;
    logic                      processing_hold;   // keeps is_processing up one more cycle

    always_comb begin
        for (int n = 0; n < neighbor_count; n++) begin
            neighbor_odd[n] = neighbors[n].is_odd_cluster;
        end
    end

    // a root with odd cardinality that cannot drain into a boundary
    assign self_odd = (state.updated_root == own_address)
                      && state.is_odd_cardinality
                      && !state.is_touching_boundary;

    // first sync cycle restarts from the root, later cycles flood from neighbors
    assign next_odd_cluster = enter_sync ? self_odd
                                         : (state.is_odd_cluster | (|neighbor_odd));

    assign spread_change = (stage == stage_spread_cluster)
                           && (min_root != state.updated_root);
    assign sync_change   = (stage == stage_sync_is_odd_cluster)
                           && (next_odd_cluster != state.is_odd_cluster);

    always_ff @(posedge clk) begin
        if (reset) begin
            state.old_root             <= own_address;
            state.updated_root         <= own_address;
            state.is_error_syndrome    <= 1'b0;
            state.is_odd_cluster       <= 1'b0;
            state.is_touching_boundary <= 1'b0;
            state.is_odd_cardinality   <= 1'b0;
        end else begin
            case (stage)
                stage_measurement_loading: begin
                    state.old_root             <= own_address;
                    state.updated_root         <= own_address;
                    state.is_error_syndrome    <= init_is_error_syndrome;
                    state.is_odd_cluster       <= init_is_error_syndrome;
                    state.is_touching_boundary <= 1'b0;
                    state.is_odd_cardinality   <= init_is_error_syndrome;
                end
                stage_spread_cluster: begin
                    state.updated_root         <= min_root;
                    state.is_odd_cluster       <= 1'b0;
                    state.is_touching_boundary <= state.is_touching_boundary
                                                  | boundary_touch;
                end
                stage_sync_is_odd_cluster: begin
                    if (enter_sync) begin
                        state.old_root <= state.updated_root;   // snapshot for neighbors
                    end
                    state.is_odd_cluster <= next_odd_cluster;
                end
                default: begin
                    // idle and grow leave the cluster state alone
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            processing_hold <= 1'b0;
        end else begin
            processing_hold <= spread_change | sync_change;
        end
    end

    assign is_processing     = spread_change | sync_change | processing_hold;
    assign neighbor_increase = enter_grow && state.is_odd_cluster;   // one pulse per grow round
    assign status            = state;

endmodule

// ==== processing_unit/processing_unit.sv ====
`timescale 1ns/1ps

module processing_unit #(
    parameter int neighbor_count   = 6,
    parameter int pos_i            = 0,
    parameter int pos_j            = 0,
    parameter int pos_k            = 0,
    parameter int code_distance_z  = 12,
    parameter int boundary_cost_z  = 2,
    parameter int boundary_cost_ud = 2
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               init_is_error_syndrome,
    input  uf_pkg::stage_t     stage_in,
    input  uf_pkg::neighbor_t  neighbors [neighbor_count],
    output logic               neighbor_increase,
    output uf_pkg::pu_status_t status,
    output logic               is_processing
);
    import uf_pkg::*;

    stage_t                    stage;
    logic                      enter_grow;
    logic                      enter_sync;
    address_t                  min_root;
    logic                      boundary_touch;
    address_t                  neighbor_roots [neighbor_count];
    logic [neighbor_count-1:0] neighbor_valids;

    // only fully grown links may pass their root on
    for (genvar n = 0; n < neighbor_count; n++) begin : g_link
        assign neighbor_roots[n]  = neighbors[n].root;
        assign neighbor_valids[n] = neighbors[n].is_fully_grown;
    end

    stage_tracker stage_tracker_i (
        .clk        (clk),
        .reset      (reset),
        .stage_in   (stage_in),
        .stage      (stage),
        .enter_grow (enter_grow),
        .enter_sync (enter_sync)
    );

    root_compare_tree #(
        .neighbor_count (neighbor_count)
    ) root_compare_tree_i (
        .default_root (status.updated_root),
        .roots        (neighbor_roots),
        .valids       (neighbor_valids),
        .min_root     (min_root)
    );

    boundary_tracker #(
        .pos_j            (pos_j),
        .pos_k            (pos_k),
        .code_distance_z  (code_distance_z),
        .boundary_cost_z  (boundary_cost_z),
        .boundary_cost_ud (boundary_cost_ud)
    ) boundary_tracker_i (
        .clk            (clk),
        .reset          (reset),
        .stage          (stage),
        .enter_grow     (enter_grow),
        .is_odd_cluster (status.is_odd_cluster),
        .boundary_touch (boundary_touch)
    );

    cluster_state #(
        .neighbor_count (neighbor_count),
        .pos_i          (pos_i),
        .pos_j          (pos_j),
        .pos_k          (pos_k)
    ) cluster_state_i (
        .clk                    (clk),
        .reset                  (reset),
        .init_is_error_syndrome (init_is_error_syndrome),
        .stage                  (stage),
        .enter_sync             (enter_sync),
        .enter_grow             (enter_grow),
        .neighbors              (neighbors),
        .min_root               (min_root),
        .boundary_touch         (boundary_touch),
        .status                 (status),
        .neighbor_increase      (neighbor_increase),
        .is_processing          (is_processing)
    );

endmodule

// ==== bench/processing_unit_assert.sv ====
`timescale 1ns/1ps

module processing_unit_assert #(
    parameter int neighbor_count = 6,
    parameter int pos_i          = 0,
    parameter int pos_j          = 0,
    parameter int pos_k          = 0
) (
    input logic               clk,
    input logic               reset,
    input logic               init_is_error_syndrome,
    input uf_pkg::stage_t     stage_in,
    input uf_pkg::neighbor_t  neighbors [neighbor_count],
    input logic               neighbor_increase,
    input uf_pkg::pu_status_t status,
    input logic               is_processing
);
    import uf_pkg::*;

    localparam address_t own_address = {coord_t'(pos_k), coord_t'(pos_i), coord_t'(pos_j)};

    int         failures = 0;   // read by the testbench at the end
    stage_t     stage_q;        // stage the unit acts on this cycle
    stage_t     stage_qq;       // stage of the cycle before
    logic [1:0] odd_grows;      // odd grow rounds since loading, stops at the cost
    address_t   spread_min;
    logic       any_neighbor_odd;
    logic       self_odd;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_q   <= stage_idle;
            stage_qq  <= stage_idle;
            odd_grows <= 2'd0;
        end else begin
            stage_q  <= stage_in;
            stage_qq <= stage_q;
            if (stage_q == stage_measurement_loading) begin
                odd_grows <= 2'd0;
            end else if (stage_q == stage_grow_boundary && stage_qq != stage_grow_boundary
                         && status.is_odd_cluster && odd_grows != 2'd2) begin
                odd_grows <= odd_grows + 2'd1;
            end
        end
    end

    // smallest root among fully grown links and the current one
    always_comb begin
        spread_min       = status.updated_root;
        any_neighbor_odd = 1'b0;
        for (int n = 0; n < neighbor_count; n++) begin
            if (neighbors[n].is_fully_grown && (neighbors[n].root < spread_min)) begin
                spread_min = neighbors[n].root;
            end
            any_neighbor_odd = any_neighbor_odd | neighbors[n].is_odd_cluster;
        end
    end

    assign self_odd = (status.updated_root == own_address) && status.is_odd_cardinality
                      && !status.is_touching_boundary;

    reset_state: assert property (@(posedge clk)
        reset |=> !neighbor_increase && !is_processing
                  && status.old_root == own_address && status.updated_root == own_address
                  && {status.is_error_syndrome, status.is_odd_cluster,
                      status.is_touching_boundary, status.is_odd_cardinality} == 4'b0)
        else begin $error("state after reset is wrong"); failures++; end

    load_state: assert property (@(posedge clk) disable iff (reset)
        stage_q == stage_measurement_loading |=>
            status.is_error_syndrome == $past(init_is_error_syndrome)
            && status.is_odd_cluster == $past(init_is_error_syndrome)
            && status.is_odd_cardinality == $past(init_is_error_syndrome)
            && !status.is_touching_boundary
            && status.old_root == own_address && status.updated_root == own_address)
        else begin $error("loaded state is wrong"); failures++; end

    spread_root: assert property (@(posedge clk) disable iff (reset)
        stage_q == stage_spread_cluster |=>
            status.updated_root == $past(spread_min) && !status.is_odd_cluster)
        else begin $error("spread result is wrong"); failures++; end

    spread_busy: assert property (@(posedge clk) disable iff (reset)
        stage_q == stage_spread_cluster && spread_min != status.updated_root |-> is_processing)
        else begin $error("is_processing low while the root changes"); failures++; end

    grow_pulse: assert property (@(posedge clk) disable iff (reset)
        neighbor_increase == (stage_q == stage_grow_boundary
                              && stage_qq != stage_grow_boundary && status.is_odd_cluster))
        else begin $error("neighbor_increase pulse is wrong"); failures++; end

    grow_touch: assert property (@(posedge clk) disable iff (reset)
        stage_q == stage_spread_cluster && odd_grows == 2'd2 |=> status.is_touching_boundary)
        else begin $error("boundary not touched after two grow rounds"); failures++; end

    sync_entry: assert property (@(posedge clk) disable iff (reset)
        stage_q == stage_sync_is_odd_cluster && stage_qq != stage_sync_is_odd_cluster |=>
            status.old_root == $past(status.updated_root)
            && status.is_odd_cluster == $past(self_odd))
        else begin $error("sync entry state is wrong"); failures++; end

    sync_flood: assert property (@(posedge clk) disable iff (reset)
        stage_q == stage_sync_is_odd_cluster && stage_qq == stage_sync_is_odd_cluster |=>
            status.is_odd_cluster == ($past(status.is_odd_cluster) | $past(any_neighbor_odd)))
        else begin $error("odd flag flood is wrong"); failures++; end

endmodule

bind processing_unit processing_unit_assert #(
    .neighbor_count (neighbor_count),
    .pos_i          (pos_i),
    .pos_j          (pos_j),
    .pos_k          (pos_k)
) assert_i (
    .clk                    (clk),
    .reset                  (reset),
    .init_is_error_syndrome (init_is_error_syndrome),
    .stage_in               (stage_in),
    .neighbors              (neighbors),
    .neighbor_increase      (neighbor_increase),
    .status                 (status),
    .is_processing          (is_processing)
);

// ==== bench/tb_processing_unit.sv ====
`timescale 1ns/1ps

module tb_processing_unit;
    import uf_pkg::*;

    localparam int neighbor_count = 6;
    localparam int settle_limit   = 20;   // cycles a stage may stay busy

    logic       clk;
    logic       reset;
    logic       init_is_error_syndrome;
    stage_t     stage_in;
    neighbor_t  neighbors [neighbor_count];
    logic       neighbor_increase;
    pu_status_t status;
    logic       is_processing;

    logic [31:0] lfsr_state = 32'h8183cc41;
    int          errors = 0;
    int          increase_pulses = 0;

    processing_unit #(
        .neighbor_count (neighbor_count),
        .pos_i          (3),
        .pos_j          (0),
        .pos_k          (0)
    ) dut_i (
        .clk                    (clk),
        .reset                  (reset),
        .init_is_error_syndrome (init_is_error_syndrome),
        .stage_in               (stage_in),
        .neighbors              (neighbors),
        .neighbor_increase      (neighbor_increase),
        .status                 (status),
        .is_processing          (is_processing)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // sampled mid-cycle away from the edge
    always @(negedge clk) begin
        if (neighbor_increase) begin
            increase_pulses++;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int width, output logic [31:0] bits);
        bits = '0;
        for (int b = 0; b < width; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits[b]    = lfsr_state[0];
        end
    endtask

    task automatic drive_neighbors(input bit allow_grown, input bit zero_root,
                                   input bit allow_odd);
        logic [31:0] bits;
        for (int n = 0; n < neighbor_count; n++) begin
            take_bits(15, bits);
            neighbors[n].root = bits[14:0];
            take_bits(1, bits);
            neighbors[n].is_fully_grown = allow_grown & bits[0];
            take_bits(1, bits);
            neighbors[n].is_odd_cluster = allow_odd & bits[0];
        end
        if (zero_root) begin
            neighbors[0].root           = '0;   // below any own address
            neighbors[0].is_fully_grown = 1'b1;
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic run_stage(input stage_t stage, input int hold);
        int cycles;
        cycles   = 0;
        stage_in = stage;
        repeat (hold) step();
        while (is_processing && cycles < settle_limit) begin
            step();
            cycles++;
        end
        if (is_processing) begin
            $display("stage %s did not settle within %0d cycles", stage.name(), settle_limit);
            errors++;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
            errors++;
        end
    endtask

    initial begin
        bit odd_run;
        bit odd_links;
        reset                  = 1'b1;
        init_is_error_syndrome = 1'b0;
        stage_in               = stage_idle;
        drive_neighbors(1'b0, 1'b0, 1'b1);
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        step();

        for (int pass = 0; pass < 2; pass++) begin
            odd_run                = (pass == 1);   // lone odd root that grows to the boundary
            init_is_error_syndrome = odd_run;
            drive_neighbors(!odd_run, 1'b0, 1'b1);
            run_stage(stage_measurement_loading, 2);
            for (int round = 0; round < 3; round++) begin
                // even links in the first even round leave the first grow without a pulse
                odd_links = odd_run || (round > 0);
                drive_neighbors(!odd_run || round == 2, odd_run && round == 2, 1'b1);
                run_stage(stage_spread_cluster, 3);
                if (odd_run && round == 2) begin
                    check_value("status.updated_root", status.updated_root, 32'h0);
                    check_value("status.is_touching_boundary",
                                status.is_touching_boundary, 32'h1);
                end
                drive_neighbors(!odd_run, 1'b0, odd_links);
                run_stage(stage_sync_is_odd_cluster, 3);
                if (round < 2) begin
                    drive_neighbors(!odd_run, 1'b0, odd_links);
                    run_stage(stage_grow_boundary, 3);
                end
            end
        end
        stage_in = stage_idle;
        repeat (2) step();   // let the last checks fire

        if (increase_pulses == 0) begin
            $display("no neighbor_increase pulse was seen during the run");
            errors++;
        end
        $display("errors: %0d testbench, %0d assertion", errors, dut_i.assert_i.failures);
        if (errors == 0 && dut_i.assert_i.failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
common/uf_pkg.sv
hw/stage_tracker.sv
hw/root_compare_tree.sv
hw/boundary_tracker.sv
processing_unit/cluster_state.sv
processing_unit/processing_unit.sv
bench/processing_unit_assert.sv
bench/tb_processing_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_processing_unit
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^sim passed$$" $(LOG) || \
		(echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
